// File: rtl/rtcBus_consts.svh
`ifndef RTC_BUS_CONSTS_SVH
`define RTC_BUS_CONSTS_SVH

////////////////////////////////////////////////////////////
// bus cycle timing, in clock cycles
////////////////////////////////////////////////////////////
`define RTC_STROBE_LEN 7 // csN/wrN low time per phase
`define RTC_GAP_LEN 7 // idle between address and data strobe
`define RTC_TAIL_LEN 7 // idle after data strobe, before ack

////////////////////////////////////////////////////////////
// chip register map
////////////////////////////////////////////////////////////
`define RTC_ADDR_STATUS0 8'h00
`define RTC_ADDR_STATUS1 8'h01
`define RTC_ADDR_STATUS2 8'h02
`define RTC_ADDR_TRIM 8'h10 // digital trimming
`define RTC_ADDR_SEC 8'h21
`define RTC_ADDR_MIN 8'h22
`define RTC_ADDR_HOUR 8'h23
`define RTC_ADDR_DATE 8'h24
`define RTC_ADDR_MONTH 8'h25
`define RTC_ADDR_YEAR 8'h26
`define RTC_ADDR_TMR_HOUR 8'h43
`define RTC_ADDR_TMR_MIN 8'h42
`define RTC_ADDR_TMR_SEC 8'h41
`define RTC_CMD_TRANSFER 8'hF1 // latch buffered regs into clock
`define RTC_CMD_TIMER 8'hF2 // latch buffered timer regs

// fixed register values
`define RTC_VAL_INIT 8'h10 // init bit of status 2
`define RTC_VAL_CLEAR 8'h00
`define RTC_VAL_TRIM 8'hD2
`define RTC_VAL_MODE 8'h0A // 24 h mode, set time lock off
`define RTC_VAL_TMR_HOUR 8'h23
`define RTC_VAL_TMR_SEC 8'h59

`endif

// File: rtl/rtcPkg.sv
package rtcPkg;

	////////////////////////////////////////////////////////////
	// host side
	////////////////////////////////////////////////////////////

	// field selected by the host, codes 0, 7 and 9..15 have no entry
	typedef enum logic [3:0]
	{
		SEC   = 4'd1,
		MIN   = 4'd2,
		HOUR  = 4'd3,
		DATE  = 4'd4,
		MONTH = 4'd5,
		YEAR  = 4'd6,
		TIMER = 4'd8 // timer branch, value goes to timer minutes
	} rtcField_t;

	typedef struct packed
	{
		rtcField_t field;
		logic [7:0] value; // bcd
	} progReq_t;

	////////////////////////////////////////////////////////////
	// chip side
	////////////////////////////////////////////////////////////

	// one register write on the chip bus
	typedef struct packed
	{
		logic [7:0] addr;
		logic [7:0] data;
	} chipWrite_t;

	typedef struct packed
	{
		logic csN; // chip select, active low
		logic wrN; // write strobe
		logic rdN; // read strobe, parked high
		logic ad; // 0 address phase, 1 data phase
		logic [7:0] bus; // multiplexed address/data byte
	} rtcBus_t;

endpackage

// File: rtl/rtcStepTable.sv
`include "rtcBus_consts.svh"

module rtcStepTable
(
	input logic [3:0] step_i,
	input rtcPkg::progReq_t progReq_i,
	output rtcPkg::chipWrite_t write_o,
	output logic last_o
);

	logic [3:0] midCount; // writes between init and closing part
	logic [3:0] closeStep; // index of the status 1 clear
	logic [3:0] midStep;
	logic [7:0] fieldAddr;

	////////////////////////////////////////////////////////////
	// program shape for the requested field
	////////////////////////////////////////////////////////////
	always_comb
	begin
		midCount = 4'd0;
		fieldAddr = `RTC_ADDR_SEC;
		case (progReq_i.field)
			rtcPkg::SEC: midCount = 4'd1;
			rtcPkg::MIN:
			begin
				midCount = 4'd1;
				fieldAddr = `RTC_ADDR_MIN;
			end
			rtcPkg::HOUR:
			begin
				midCount = 4'd1;
				fieldAddr = `RTC_ADDR_HOUR;
			end
			rtcPkg::DATE:
			begin
				midCount = 4'd1;
				fieldAddr = `RTC_ADDR_DATE;
			end
			rtcPkg::MONTH:
			begin
				midCount = 4'd1;
				fieldAddr = `RTC_ADDR_MONTH;
			end
			rtcPkg::YEAR:
			begin
				midCount = 4'd1;
				fieldAddr = `RTC_ADDR_YEAR;
			end
			rtcPkg::TIMER: midCount = 4'd4;
			default: midCount = 4'd0; // unlisted code, straight to closing
		endcase
	end

	assign closeStep = 4'd4 + midCount;
	assign midStep = step_i - 4'd4;

	////////////////////////////////////////////////////////////
	// write for the current step
	////////////////////////////////////////////////////////////
	always_comb
	begin
		write_o = '{`RTC_ADDR_STATUS1, `RTC_VAL_CLEAR};
		last_o = 1'b0;
		if (step_i < 4'd4)
		begin
			case (step_i[1:0])
				2'd0: write_o = '{`RTC_ADDR_STATUS2, `RTC_VAL_INIT}; // set init bit
				2'd1: write_o = '{`RTC_ADDR_STATUS2, `RTC_VAL_CLEAR}; // and release it
				2'd2: write_o = '{`RTC_ADDR_TRIM, `RTC_VAL_TRIM};
				default: write_o = '{`RTC_ADDR_STATUS0, `RTC_VAL_MODE};
			endcase
		end
		else if (step_i < closeStep)
		begin
			if (progReq_i.field == rtcPkg::TIMER)
			begin
				case (midStep[1:0])
					2'd0: write_o = '{`RTC_ADDR_TMR_HOUR, `RTC_VAL_TMR_HOUR};
					2'd1: write_o = '{`RTC_ADDR_TMR_MIN, progReq_i.value};
					2'd2: write_o = '{`RTC_ADDR_TMR_SEC, `RTC_VAL_TMR_SEC};
					default: write_o = '{`RTC_CMD_TIMER, `RTC_CMD_TIMER};
				endcase
			end
			else
				write_o = '{fieldAddr, progReq_i.value}; // single clock field
		end
		else if (step_i == closeStep)
			write_o = '{`RTC_ADDR_STATUS1, `RTC_VAL_CLEAR};
		else
		begin
			write_o = '{`RTC_CMD_TRANSFER, `RTC_CMD_TRANSFER};
			last_o = 1'b1;
		end
	end

endmodule

// File: rtl/rtcSequencer.sv
module rtcSequencer
(
	input logic clk_i,
	input logic reset,
	input logic progValid_i,
	input rtcPkg::progReq_t progReq_i,
	output logic progAck_o,
	output logic [3:0] step_o,
	output rtcPkg::progReq_t reqLatched_o,
	input logic last_i,
	output logic wrReq_o,
	input logic wrAck_i
);

	typedef enum logic [2:0]
	{
		sIdle,
		sIssue, // raise wrReq for the current step
		sWaitAck, // bus cycle running
		sRelease, // wrReq dropped, wait for ack to fall
		sDone // program complete, hold progAck
	} seqState_t;

	seqState_t state;
	logic capture;

	assign capture = (state == sIdle) && progValid_i;

	////////////////////////////////////////////////////////////
	// control FSM
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_i)
	begin
		if (reset)
		begin
			state <= sIdle;
			step_o <= 4'd0;
			wrReq_o <= 1'b0;
			progAck_o <= 1'b0;
		end
		else
		begin
			case (state)
				sIdle:
				begin
					if (progValid_i)
					begin
						step_o <= 4'd0;
						state <= sIssue;
					end
				end
				sIssue:
				begin
					wrReq_o <= 1'b1; // table output is already stable
					state <= sWaitAck;
				end
				sWaitAck:
				begin
					if (wrAck_i)
					begin
						wrReq_o <= 1'b0;
						state <= sRelease;
					end
				end
				sRelease:
				begin
					if (!wrAck_i)
					begin
						if (last_i)
						begin
							progAck_o <= 1'b1;
							state <= sDone;
						end
						else
						begin
							step_o <= step_o + 4'd1;
							state <= sIssue;
						end
					end
				end
				sDone:
				begin
					if (!progValid_i) // host released its request
					begin
						progAck_o <= 1'b0;
						state <= sIdle;
					end
				end
				default: state <= sIdle;
			endcase
		end
	end

	// request is held for the whole program
	always_ff @(posedge clk_i)
	begin
		if (capture)
			reqLatched_o <= progReq_i;
	end

	// a new write only starts once the writer has closed the last handshake
	noReqDuringAck: assert property (@(posedge clk_i) disable iff (reset)
		$rose(wrReq_o) |-> !wrAck_i);

endmodule

// File: rtl/rtcBusWriter.sv
`include "rtcBus_consts.svh"

module rtcBusWriter
(
	input logic clk_i,
	input logic reset,
	input logic wrReq_i,
	input rtcPkg::chipWrite_t wrCmd_i,
	output logic wrAck_o,
	output rtcPkg::rtcBus_t rtcBus_o
);

	////////////////////////////////////////////////////////////
	// phase boundaries, counted from the accepting edge
	////////////////////////////////////////////////////////////
	localparam logic [4:0] ADDR_END = 5'(`RTC_STROBE_LEN);
	localparam logic [4:0] DATA_START = 5'(`RTC_STROBE_LEN + `RTC_GAP_LEN);
	localparam logic [4:0] DATA_END = 5'(2 * `RTC_STROBE_LEN + `RTC_GAP_LEN);
	localparam logic [4:0] CYCLE_END = 5'(2 * `RTC_STROBE_LEN + `RTC_GAP_LEN
		+ `RTC_TAIL_LEN);

	logic [4:0] phaseCnt; // zero when idle
	logic start;

	assign start = (phaseCnt == 5'd0) && wrReq_i && !wrAck_o;

	always_ff @(posedge clk_i)
	begin
		if (reset)
		begin
			phaseCnt <= 5'd0;
			wrAck_o <= 1'b0;
			rtcBus_o.csN <= 1'b1;
			rtcBus_o.wrN <= 1'b1;
			rtcBus_o.rdN <= 1'b1;
			rtcBus_o.ad <= 1'b0;
			rtcBus_o.bus <= 8'h00;
		end
		else if (phaseCnt == 5'd0)
		begin
			if (start)
			begin
				phaseCnt <= 5'd1;
				rtcBus_o.csN <= 1'b0; // address strobe
				rtcBus_o.wrN <= 1'b0;
				rtcBus_o.rdN <= 1'b1;
				rtcBus_o.ad <= 1'b0;
				rtcBus_o.bus <= wrCmd_i.addr;
			end
			else if (!wrReq_i)
				wrAck_o <= 1'b0; // close the four-phase handshake
		end
		else
		begin
			phaseCnt <= phaseCnt + 5'd1;
			case (phaseCnt)
				ADDR_END, DATA_END:
				begin
					rtcBus_o.csN <= 1'b1;
					rtcBus_o.wrN <= 1'b1;
				end
				DATA_START:
				begin
					rtcBus_o.csN <= 1'b0; // data strobe
					rtcBus_o.wrN <= 1'b0;
					rtcBus_o.ad <= 1'b1;
					rtcBus_o.bus <= wrCmd_i.data; // wrCmd held while wrReq high
				end
				CYCLE_END:
				begin
					phaseCnt <= 5'd0;
					wrAck_o <= 1'b1;
				end
				default:
				begin
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// pin protocol
	////////////////////////////////////////////////////////////
	strobeWrite: assert property (@(posedge clk_i) disable iff (reset)
		!rtcBus_o.csN |-> !rtcBus_o.wrN && rtcBus_o.rdN);

	// phase select and byte hold for the whole strobe
	phaseStable: assert property (@(posedge clk_i) disable iff (reset)
		!rtcBus_o.csN && $past(!rtcBus_o.csN) |-> $stable(rtcBus_o.ad)
		&& $stable(rtcBus_o.bus));

endmodule

// File: rtl/rtcWriteSeq.sv
module rtcWriteSeq
(
	input logic clk_i,
	input logic reset,
	input logic progValid_i,
	input rtcPkg::progReq_t progReq_i,
	output logic progAck_o,
	output rtcPkg::rtcBus_t rtcBus_o
);

	logic wrReq;
	logic wrAck;
	rtcPkg::chipWrite_t wrCmd; // straight from the step table
	logic [3:0] step;
	rtcPkg::progReq_t reqLatched;
	logic last;

	rtcSequencer seq_i (
		.clk_i(clk_i),
		.reset(reset),
		.progValid_i(progValid_i),
		.progReq_i(progReq_i),
		.progAck_o(progAck_o),
		.step_o(step),
		.reqLatched_o(reqLatched),
		.last_i(last),
		.wrReq_o(wrReq),
		.wrAck_i(wrAck)
	);

	rtcStepTable table_i (
		.step_i(step),
		.progReq_i(reqLatched),
		.write_o(wrCmd),
		.last_o(last)
	);

	rtcBusWriter writer_i (
		.clk_i(clk_i),
		.reset(reset),
		.wrReq_i(wrReq),
		.wrCmd_i(wrCmd),
		.wrAck_o(wrAck),
		.rtcBus_o(rtcBus_o)
	);

endmodule

// File: sim/rtcWriteSeqTb.sv
`include "rtcBus_consts.svh"

module rtcWriteSeqTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_ROWS = 9;
	localparam int ACK_LIMIT = 10 * 40; // cycles allowed for one program
	localparam int HOLD_CYCLES = 5; // host keeps progValid up after ack

	logic clk_i = 1'b0;
	logic reset = 1'b1;
	logic progValid = 1'b0;
	rtcPkg::progReq_t progReq = '0;
	logic progAck;
	rtcPkg::rtcBus_t rtcBus;

	string nameTab [NUM_ROWS];
	logic [3:0] fieldTab [NUM_ROWS];
	logic [7:0] valueTab [NUM_ROWS];

	logic [15:0] expWrites [$]; // {addr, data}
	logic [15:0] obsWrites [$];
	string curName = "reset";
	int errorCount = 0;
	int rowErrors = 0;
	int passCount = 0;
	int failCount = 0;

	rtcWriteSeq dut_i (
		.clk_i(clk_i),
		.reset(reset),
		.progValid_i(progValid),
		.progReq_i(progReq),
		.progAck_o(progAck),
		.rtcBus_o(rtcBus)
	);

	initial
	begin
		forever
			#5 clk_i = ~clk_i;
	end

	initial
	begin
		#(NUM_ROWS * 10 * 40 * 10 * 2);
		$display("watchdog expired, the run did not finish in time");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	task automatic countError();
		errorCount++;
		rowErrors++;
	endtask

	function automatic logic [7:0] randomBcd(input int maxTens);
		logic [3:0] tens;
		logic [3:0] units;
		tens = 4'($urandom % maxTens);
		units = 4'($urandom % 10);
		return {tens, units};
	endfunction

	////////////////////////////////////////////////////////////
	// expected chip writes for one host request
	////////////////////////////////////////////////////////////
	task automatic buildExpected(input logic [3:0] field, input logic [7:0] value);
		expWrites.delete();
		expWrites.push_back({`RTC_ADDR_STATUS2, `RTC_VAL_INIT});
		expWrites.push_back({`RTC_ADDR_STATUS2, `RTC_VAL_CLEAR});
		expWrites.push_back({`RTC_ADDR_TRIM, `RTC_VAL_TRIM});
		expWrites.push_back({`RTC_ADDR_STATUS0, `RTC_VAL_MODE});
		case (field)
			4'd1: expWrites.push_back({`RTC_ADDR_SEC, value});
			4'd2: expWrites.push_back({`RTC_ADDR_MIN, value});
			4'd3: expWrites.push_back({`RTC_ADDR_HOUR, value});
			4'd4: expWrites.push_back({`RTC_ADDR_DATE, value});
			4'd5: expWrites.push_back({`RTC_ADDR_MONTH, value});
			4'd6: expWrites.push_back({`RTC_ADDR_YEAR, value});
			4'd8:
			begin
				expWrites.push_back({`RTC_ADDR_TMR_HOUR, `RTC_VAL_TMR_HOUR});
				expWrites.push_back({`RTC_ADDR_TMR_MIN, value});
				expWrites.push_back({`RTC_ADDR_TMR_SEC, `RTC_VAL_TMR_SEC});
				expWrites.push_back({`RTC_CMD_TIMER, `RTC_CMD_TIMER});
			end
			default:
			begin
			end
		endcase
		expWrites.push_back({`RTC_ADDR_STATUS1, `RTC_VAL_CLEAR});
		expWrites.push_back({`RTC_CMD_TRANSFER, `RTC_CMD_TRANSFER});
	endtask

	////////////////////////////////////////////////////////////
	// bus monitor, sampled mid-cycle
	////////////////////////////////////////////////////////////
	logic prevCsN = 1'b1;
	int lowCount = 0;
	logic [7:0] pendAddr = 8'h00;
	bit addrPending = 1'b0;

	always @(negedge clk_i)
	begin
		if (!reset)
		begin
			if (rtcBus.rdN !== 1'b1)
			begin
				$display("CHECK FAILED %s rdN expected 1 actual %b", curName, rtcBus.rdN);
				countError();
			end
			if (rtcBus.wrN !== rtcBus.csN) // write strobe moves with chip select
			begin
				$display("CHECK FAILED %s wrN expected %b actual %b",
					curName, rtcBus.csN, rtcBus.wrN);
				countError();
			end
			if (prevCsN && !rtcBus.csN) // strobe starts
			begin
				lowCount = 1;
				if (!rtcBus.ad)
				begin
					if (addrPending)
					begin
						$display("%s: address strobe without a following data strobe", curName);
						countError();
					end
					pendAddr = rtcBus.bus;
					addrPending = 1'b1;
				end
				else if (!addrPending)
				begin
					$display("%s: data strobe with no address strobe before it", curName);
					countError();
				end
				else
				begin
					obsWrites.push_back({pendAddr, rtcBus.bus});
					addrPending = 1'b0;
				end
			end
			else if (!rtcBus.csN)
				lowCount++;
			else if (!prevCsN && lowCount != `RTC_STROBE_LEN)
			begin
				$display("CHECK FAILED %s strobe length expected %0d actual %0d",
					curName, `RTC_STROBE_LEN, lowCount);
				countError();
			end
			prevCsN = rtcBus.csN;
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus table and row loop
	////////////////////////////////////////////////////////////
	initial
	begin
		int waited;
		void'($urandom(52));
		nameTab = '{"sec", "min", "hour", "date", "month", "year", "randTimer",
			"unlisted7", "randHour"};
		fieldTab = '{4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd8, 4'd7, 4'd3};
		valueTab = '{8'h45, 8'h30, 8'h23, 8'h31, 8'h12, 8'h99, 8'h15, 8'h55, 8'h00};
		valueTab[8] = randomBcd(3);
		valueTab[6] = randomBcd(6); // timer minutes row is randomized too

		repeat (3) @(posedge clk_i);
		reset <= 1'b0;
		@(negedge clk_i);
		if ({rtcBus.csN, rtcBus.wrN, rtcBus.rdN, rtcBus.ad, progAck, rtcBus.bus}
			!== {5'b11100, 8'h00})
		begin
			$display("CHECK FAILED %s csN,wrN,rdN,ad,progAck,bus expected %b actual %b",
				curName, {5'b11100, 8'h00},
				{rtcBus.csN, rtcBus.wrN, rtcBus.rdN, rtcBus.ad, progAck, rtcBus.bus});
			countError();
		end

		for (int r = 0; r < NUM_ROWS; r++)
		begin
			curName = nameTab[r];
			rowErrors = 0;
			obsWrites.delete();
			buildExpected(fieldTab[r], valueTab[r]);
			@(posedge clk_i);
			progReq <= rtcPkg::progReq_t'({fieldTab[r], valueTab[r]});
			progValid <= 1'b1;
			waited = 0;
			@(negedge clk_i);
			while (!progAck && waited < ACK_LIMIT)
			begin
				@(negedge clk_i);
				waited++;
			end
			if (!progAck)
			begin
				$display("%s: no progAck within %0d cycles", curName, ACK_LIMIT);
				countError();
			end
			else if (obsWrites.size() != expWrites.size())
			begin
				$display("CHECK FAILED %s writes at ack expected %0d actual %0d",
					curName, expWrites.size(), obsWrites.size());
				countError();
			end
			repeat (HOLD_CYCLES)
			begin
				@(negedge clk_i);
				if (progAck !== 1'b1)
				begin
					$display("CHECK FAILED %s progAck while held expected 1 actual %b",
						curName, progAck);
					countError();
				end
			end
			@(posedge clk_i);
			progValid <= 1'b0;
			@(posedge clk_i);
			@(negedge clk_i);
			if (progAck !== 1'b0)
			begin
				$display("CHECK FAILED %s progAck after release expected 0 actual %b",
					curName, progAck);
				countError();
			end
			if (obsWrites.size() != expWrites.size())
			begin
				$display("CHECK FAILED %s write count expected %0d actual %0d",
					curName, expWrites.size(), obsWrites.size());
				countError();
			end
			for (int i = 0; i < expWrites.size() && i < obsWrites.size(); i++)
			begin
				if (obsWrites[i] !== expWrites[i])
				begin
					$display("CHECK FAILED %s write %0d expected %h actual %h",
						curName, i, expWrites[i], obsWrites[i]);
					countError();
				end
			end
			if (rowErrors == 0)
			begin
				passCount++;
				$display("%s: passed, %0d writes", curName, obsWrites.size());
			end
			else
			begin
				failCount++;
				$display("%s: failed with %0d errors", curName, rowErrors);
			end
		end

		$display("tests %0d, passed %0d, failed %0d, errors %0d",
			NUM_ROWS, passCount, failCount, errorCount);
		if (errorCount == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: sources.f
+incdir+rtl
rtl/rtcPkg.sv
rtl/rtcStepTable.sv
rtl/rtcSequencer.sv
rtl/rtcBusWriter.sv
rtl/rtcWriteSeq.sv
sim/rtcWriteSeqTb.sv
